/* intra_pred.f */
+incdir+.
intra_pkg.sv
intra_pipe_reg.sv
intra_req_ctrl.sv
intra_dc_accum.sv
intra_scan.sv
intra_pixel_calc.sv
intra_pred_top.sv
tb_intra_pred.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f intra_pred.f --top-module tb_intra_pred -o sim_intra_pred

sim_out=$(./obj_dir/sim_intra_pred)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

/* tb_intra_pred.sv */
/*
 * Directed testbench for the intra prediction engine
 * Four-phase driver, beat collector, reference model, timeout
 */

`timescale 1ns/1ps
`include "intra_macros.svh"

module tb_intra_pred;

    localparam int MAX_PIX        = `INTRA_MAX_N * `INTRA_MAX_N;
    // V/H 160, DC 80, Paeth 144, back-pressure 80, unsupported 80
    localparam int TOTAL_PIXELS   = 544;
    localparam int TIMEOUT_CYCLES = TOTAL_PIXELS * 4 + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    intra_pkg::intra_req_t req_data;
    logic                  ack;
    intra_pkg::pix_beat_t  out_beat;
    logic                  out_valid;
    logic                  out_ready;

    integer seed;
    int     errors;
    int     cycle_cnt;
    int     got_count;
    int     got_pix  [MAX_PIX];
    logic   got_last [MAX_PIX];
    int     exp_pix  [MAX_PIX];

    intra_pred_top intra_pred_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
        $display("Stopped with %0d errors", errors);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_value(input int got, input int exp, input string msg);
        if (got != exp) begin
            errors++;
            $display("** Error at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic draw_pixel(input bit narrow, output intra_pkg::pixel_t px);
        int r;
        r = $random(seed);
        // Narrow spread 100..104 puts many Paeth distances level
        if (narrow) begin
            px = intra_pkg::pixel_t'(100 + ((r & 32'h7fff_ffff) % 5));
        end else begin
            px = intra_pkg::pixel_t'(r & 32'h3ff);
        end
    endtask

    task automatic build_req(input int mode, input int lg, input bit narrow,
                             output intra_pkg::intra_req_t r);
        intra_pkg::pixel_t px;
        int                i;
        r           = '0;
        r.mode      = intra_pkg::intra_mode_e'(mode[2:0]);
        r.size_log2 = intra_pkg::blk_log2_t'(lg);
        draw_pixel(narrow, px);
        // Top-left in the middle of the narrow spread so ties pick distinct pixels
        r.top_left = narrow ? intra_pkg::pixel_t'(102) : px;
        for (i = 0; i < `INTRA_MAX_N; i++) begin
            draw_pixel(narrow, px);
            r.ref_top[i] = px;
            draw_pixel(narrow, px);
            r.ref_left[i] = px;
        end
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    task automatic model_block(input intra_pkg::intra_req_t r);
        int n, i, row, col, sum, dc, t, l, tl, base, d_l, d_t, d_tl, px;
        n   = 1 << int'(r.size_log2);
        sum = 0;
        for (i = 0; i < n; i++) begin
            sum += int'(r.ref_top[i]) + int'(r.ref_left[i]);
        end
        dc = (sum + n) / (2 * n);
        tl = int'(r.top_left);
        for (row = 0; row < n; row++) begin
            for (col = 0; col < n; col++) begin
                t = int'(r.ref_top[col]);
                l = int'(r.ref_left[row]);
                case (int'(r.mode))
                    0: px = dc;
                    1: px = t;
                    2: px = l;
                    3: begin
                        base = t + l - tl;
                        d_l  = (base > l) ? base - l : l - base;
                        d_t  = (base > t) ? base - t : t - base;
                        d_tl = (base > tl) ? base - tl : tl - base;
                        if (d_l <= d_t && d_l <= d_tl) px = l;
                        else if (d_t <= d_tl) px = t;
                        else px = tl;
                    end
                    default: px = `INTRA_MID_PIXEL;
                endcase
                exp_pix[row * n + col] = px;
            end
        end
    endtask

    // Four-phase request with beats sampled at the falling edge
    task send_block(input intra_pkg::intra_req_t r, input bit stall);
        int   r_bits;
        logic done;
        got_count = 0;
        done      = 1'b0;
        @(posedge clk);
        #1;
        req_data = r;
        req      = 1'b1;
        while (!done) begin
            @(negedge clk);
            if (ack) begin
                done = 1'b1;
            end else begin
                if (out_valid && out_ready) begin
                    if (got_count < MAX_PIX) begin
                        got_pix[got_count]  = int'(out_beat.pixel);
                        got_last[got_count] = out_beat.last;
                    end
                    got_count++;
                end
                @(posedge clk);
                #1;
                r_bits    = $random(seed);
                out_ready = stall ? r_bits[0] : 1'b1;
            end
        end
        @(posedge clk);
        #1;
        req       = 1'b0;
        out_ready = 1'b1;
        @(negedge clk);
        check_value(int'(ack), 1, "ack held until req is seen low");
        @(negedge clk);
        check_value(int'(ack), 0, "ack one cycle after req seen low");
    endtask

    task automatic verify_block(input intra_pkg::intra_req_t r, input string name);
        int n_pix, i;
        n_pix = 1 << (2 * int'(r.size_log2));
        model_block(r);
        if (got_count != n_pix) begin
            errors++;
            $display("%s: ack came after %0d pixels, %0d were expected",
                     name, got_count, n_pix);
        end
        for (i = 0; i < n_pix && i < got_count; i++) begin
            check_value(got_pix[i], exp_pix[i], $sformatf("%s pixel %0d", name, i));
            if (i == n_pix - 1 && !got_last[i]) begin
                errors++;
                $display("%s: the final pixel arrived without its last flag", name);
            end else if (i < n_pix - 1 && got_last[i]) begin
                errors++;
                $display("%s: last flag set on pixel %0d before the block end", name, i);
            end
        end
    endtask

    task run_block(input int mode, input int lg, input bit narrow, input bit stall,
                   input string name);
        intra_pkg::intra_req_t r;
        build_req(mode, lg, narrow, r);
        send_block(r, stall);
        verify_block(r, name);
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task test_vert_horz();
        run_block(1, 2, 1'b0, 1'b0, "V 4x4");
        run_block(1, 3, 1'b0, 1'b0, "V 8x8");
        run_block(2, 2, 1'b0, 1'b0, "H 4x4");
        run_block(2, 3, 1'b0, 1'b0, "H 8x8");
    endtask

    task test_dc();
        run_block(0, 2, 1'b0, 1'b0, "DC 4x4");
        run_block(0, 3, 1'b0, 1'b0, "DC 8x8");
    endtask

    task test_paeth();
        run_block(3, 2, 1'b0, 1'b0, "Paeth 4x4");
        run_block(3, 3, 1'b0, 1'b0, "Paeth 8x8");
        run_block(3, 3, 1'b1, 1'b0, "Paeth 8x8 ties");
    endtask

    task test_back_pressure();
        run_block(3, 3, 1'b0, 1'b1, "Paeth 8x8 stalled");
        run_block(0, 2, 1'b0, 1'b1, "DC 4x4 stalled");
    endtask

    // Two blocks back to back with an unsupported mode code
    task test_unsupported();
        run_block(6, 2, 1'b0, 1'b0, "Mode 6 4x4");
        run_block(6, 3, 1'b0, 1'b0, "Mode 6 8x8");
    endtask

    initial begin
        seed      = 32'h8c48_2ace;
        errors    = 0;
        rst_n     = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value(int'(ack), 0, "ack after reset");
        test_vert_horz();
        test_dc();
        test_paeth();
        test_back_pressure();
        test_unsupported();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* intra_pred_top.sv */
/*
 * Intra prediction engine top level
 * Request control, DC accumulator, scan, two register slices, predictor
 */

`timescale 1ns/1ps

module intra_pred_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  intra_pkg::intra_req_t  req_data,
    output logic                   ack,
    output intra_pkg::pix_beat_t   out_beat,
    output logic                   out_valid,
    input  logic                   out_ready
);

    intra_pkg::intra_req_t  req_reg;
    intra_pkg::pixel_t      dc_value;
    intra_pkg::scan_pos_t   scan_pos;
    intra_pkg::scan_pos_t   slice_pos;
    intra_pkg::pix_beat_t   calc_beat;
    logic                   dc_start;
    logic                   dc_done;
    logic                   scan_start;
    logic                   scan_valid;
    logic                   scan_ready;
    logic                   slice_pos_valid;
    logic                   slice_pos_ready;
    logic                   last_accepted;

    assign last_accepted = out_valid && out_ready && out_beat.last;

    intra_req_ctrl req_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .req_data      (req_data),
        .ack           (ack),
        .req_reg       (req_reg),
        .dc_start      (dc_start),
        .dc_done       (dc_done),
        .scan_start    (scan_start),
        .last_accepted (last_accepted)
    );

    intra_dc_accum dc_accum_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (dc_start),
        .req_reg  (req_reg),
        .dc_value (dc_value),
        .done     (dc_done)
    );

    // Block end is taken from the output side, scan done stays local
    intra_scan scan_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (scan_start),
        .size_log2 (req_reg.size_log2),
        .pos       (scan_pos),
        .pos_valid (scan_valid),
        .pos_ready (scan_ready),
        .done      ()
    );

    intra_pipe_reg #(.payload_t(intra_pkg::scan_pos_t)) pos_slice_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (scan_pos),
        .in_valid  (scan_valid),
        .in_ready  (scan_ready),
        .out_data  (slice_pos),
        .out_valid (slice_pos_valid),
        .out_ready (slice_pos_ready)
    );

    intra_pixel_calc pixel_calc_i (
        .req_reg  (req_reg),
        .dc_value (dc_value),
        .pos      (slice_pos),
        .beat     (calc_beat)
    );

    intra_pipe_reg #(.payload_t(intra_pkg::pix_beat_t)) beat_slice_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (calc_beat),
        .in_valid  (slice_pos_valid),
        .in_ready  (slice_pos_ready),
        .out_data  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* intra_pixel_calc.sv */
/*
 * Per-pixel predictor
 * DC, vertical, horizontal, Paeth and mid-grey fill
 */

`timescale 1ns/1ps
`include "intra_macros.svh"

module intra_pixel_calc (
    input  intra_pkg::intra_req_t  req_reg,
    input  intra_pkg::pixel_t      dc_value,
    input  intra_pkg::scan_pos_t   pos,
    output intra_pkg::pix_beat_t   beat
);

    intra_pkg::pixel_t   top_px;
    intra_pkg::pixel_t   left_px;
    intra_pkg::pixel_t   paeth_px;
    logic signed [11:0]  base;
    logic [11:0]         d_left;
    logic [11:0]         d_top;
    logic [11:0]         d_tl;

    function automatic logic [11:0] abs12(input logic signed [11:0] v);
        if (v < 0) begin
            return -v;
        end
        return v;
    endfunction

    assign top_px  = req_reg.ref_top[pos.col];
    assign left_px = req_reg.ref_left[pos.row];

    // ========================================================================
    // Paeth, ties resolve left then top then top-left
    // ========================================================================
    always_comb begin
        base   = $signed({2'b00, top_px}) + $signed({2'b00, left_px})
               - $signed({2'b00, req_reg.top_left});
        d_left = abs12(base - $signed({2'b00, left_px}));
        d_top  = abs12(base - $signed({2'b00, top_px}));
        d_tl   = abs12(base - $signed({2'b00, req_reg.top_left}));
        if (d_left <= d_top && d_left <= d_tl) begin
            paeth_px = left_px;
        end else if (d_top <= d_tl) begin
            paeth_px = top_px;
        end else begin
            paeth_px = req_reg.top_left;
        end
    end

    always_comb begin
        beat.last = pos.last;
        case (req_reg.mode)
            intra_pkg::MODE_DC:    beat.pixel = dc_value;
            intra_pkg::MODE_V:     beat.pixel = top_px;
            intra_pkg::MODE_H:     beat.pixel = left_px;
            intra_pkg::MODE_PAETH: beat.pixel = paeth_px;
            default:               beat.pixel = intra_pkg::pixel_t'(`INTRA_MID_PIXEL);
        endcase
    end

endmodule

/* intra_scan.sv */
/*
 * Row-major scan of an NxN block
 * Issues one position per accepted beat, last flag on the final one
 */

`timescale 1ns/1ps

module intra_scan (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  intra_pkg::blk_log2_t  size_log2,
    output intra_pkg::scan_pos_t  pos,
    output logic                  pos_valid,
    input  logic                  pos_ready,
    output logic                  done
);

    logic       active;
    logic [2:0] row;
    logic [2:0] col;
    logic [3:0] n;
    logic [3:0] n_m1;
    logic       fire;

    assign n    = 4'd1 << size_log2;
    assign n_m1 = n - 4'd1;

    assign pos.row   = row;
    assign pos.col   = col;
    assign pos.last  = (row == n_m1[2:0]) && (col == n_m1[2:0]);
    assign pos_valid = active;

    assign fire = active && pos_ready;
    assign done = fire && pos.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            row    <= 3'd0;
            col    <= 3'd0;
        end else if (start) begin
            active <= 1'b1;
            row    <= 3'd0;
            col    <= 3'd0;
        end else if (fire) begin
            if (done) begin
                active <= 1'b0;
            end else if (col == n_m1[2:0]) begin
                col <= 3'd0;
                row <= row + 3'd1;
            end else begin
                col <= col + 3'd1;
            end
        end
    end

    a_col_in_block: assert property (@(posedge clk) disable iff (!rst_n)
        pos_valid |-> ({1'b0, pos.col} < n));

endmodule

/* intra_dc_accum.sv */
/*
 * Serial DC accumulator
 * One top and one left neighbour per cycle, rounded shift at the end
 */

`timescale 1ns/1ps
`include "intra_macros.svh"

module intra_dc_accum (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  intra_pkg::intra_req_t  req_reg,
    output intra_pkg::pixel_t      dc_value,
    output logic                   done
);

    // Sum of 2N pixels plus rounding term
    localparam int SUM_W = `INTRA_BIT_DEPTH + $clog2(2 * `INTRA_MAX_N);

    logic             busy;
    logic [2:0]       idx;
    logic [2:0]       sel_idx;
    logic [3:0]       n;
    logic [3:0]       n_m1;
    logic [2:0]       shift_amt;
    logic             last_step;
    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] sum_base;
    logic [SUM_W-1:0] sum_next;
    logic [SUM_W-1:0] rounded;

    assign n         = 4'd1 << req_reg.size_log2;
    assign n_m1      = n - 4'd1;
    assign shift_amt = {1'b0, req_reg.size_log2} + 3'd1;
    assign last_step = busy && (idx == n_m1[2:0]);

    // Start cycle adds entry 0 onto an empty sum
    always_comb begin
        sel_idx  = start ? 3'd0 : idx;
        sum_base = start ? '0 : sum;
        sum_next = sum_base + SUM_W'(req_reg.ref_top[sel_idx])
                            + SUM_W'(req_reg.ref_left[sel_idx]);
        rounded  = sum_next + SUM_W'(n);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= 3'd0;
            done <= 1'b0;
        end else begin
            done <= last_step;
            if (start) begin
                busy <= 1'b1;
                idx  <= 3'd1;
            end else if (busy) begin
                idx <= idx + 3'd1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            sum <= sum_next;
        end
        if (last_step) begin
            dc_value <= intra_pkg::pixel_t'(rounded >> shift_amt);
        end
    end

endmodule

/* intra_req_ctrl.sv */
/*
 * Four-phase req/ack front end
 * Request capture and block sequencing FSM (DC sum, scan, ack)
 */

`timescale 1ns/1ps

module intra_req_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  intra_pkg::intra_req_t  req_data,
    output logic                   ack,
    output intra_pkg::intra_req_t  req_reg,
    output logic                   dc_start,
    input  logic                   dc_done,
    output logic                   scan_start,
    input  logic                   last_accepted
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DC,
        ST_SCAN,
        ST_ACK_HIGH,
        ST_WAIT_LOW
    } state_e;

    state_e state;

    // ========================================================================
    // Sequencing FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            dc_start   <= 1'b0;
            scan_start <= 1'b0;
        end else begin
            dc_start   <= 1'b0;
            scan_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state    <= ST_DC;
                        dc_start <= 1'b1;
                    end
                end
                ST_DC: begin
                    if (dc_done) begin
                        state      <= ST_SCAN;
                        scan_start <= 1'b1;
                    end
                end
                ST_SCAN: begin
                    if (last_accepted) begin
                        state <= ST_ACK_HIGH;
                    end
                end
                ST_ACK_HIGH: begin
                    if (!req) begin
                        state <= ST_WAIT_LOW;
                    end
                end
                // Ack already low, next request is taken from idle
                ST_WAIT_LOW: state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // Request held for the whole block
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            req_reg <= req_data;
        end
    end

    assign ack = (state == ST_ACK_HIGH);

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req);

endmodule

/* intra_pipe_reg.sv */
/*
 * Single-entry valid/ready register slice, payload given as a type
 */

`timescale 1ns/1ps

module intra_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            out_data <= in_data;
        end
    end

    // Upstream keeps its beat while this slice is full
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

/* intra_pkg.sv */
/*
 * Intra predictor types
 * Pixel, mode code, block size, request, scan position, output beat
 */

`include "intra_macros.svh"

package intra_pkg;

    typedef logic [`INTRA_BIT_DEPTH-1:0] pixel_t;

    // Codes 4..7 are unsupported and give a flat mid-grey block
    typedef enum logic [2:0] {
        MODE_DC    = 3'd0,
        MODE_V     = 3'd1,
        MODE_H     = 3'd2,
        MODE_PAETH = 3'd3
    } intra_mode_e;

    // log2 of the block side, 2 or 3
    typedef logic [1:0] blk_log2_t;

    typedef struct packed {
        intra_mode_e                   mode;
        blk_log2_t                     size_log2;
        pixel_t                        top_left;
        pixel_t [`INTRA_MAX_N-1:0]     ref_top;
        pixel_t [`INTRA_MAX_N-1:0]     ref_left;
    } intra_req_t;

    typedef struct packed {
        logic [$clog2(`INTRA_MAX_N)-1:0] row;
        logic [$clog2(`INTRA_MAX_N)-1:0] col;
        logic                            last;
    } scan_pos_t;

    typedef struct packed {
        pixel_t pixel;
        logic   last;
    } pix_beat_t;

endpackage

/* intra_macros.svh */
/*
 * Global sizing for the intra predictor
 * Pixel bit depth, largest block side, mid-grey fill value
 */

`ifndef INTRA_MACROS_SVH
`define INTRA_MACROS_SVH

// Pixel width in bits
`define INTRA_BIT_DEPTH 10

// Largest block side, 8x8
`define INTRA_MAX_N 8

// Fill for unsupported modes
`define INTRA_MID_PIXEL 512

`endif
